// File: rtl/h264_pkg.sv
package h264_pkg;

    //////////////////////////////////////////////////////////////////////
    // frame geometry

    localparam int frame_w = 32;
    localparam int frame_h = 32;
    localparam int last_x  = 28;   // top-left corner of the final 4x4 block.
    localparam int last_y  = 28;
    localparam int pos_w   = 10;

    //////////////////////////////////////////////////////////////////////
    // block coefficients and codes

    localparam int coef_w         = 3;
    localparam int num_coefs      = 16;
    localparam int code_w         = 128;
    localparam int code_len_w     = 7;
    localparam int max_block_bits = 112;  // 16 codes of 7 bits, all coefficients -4.

    //////////////////////////////////////////////////////////////////////
    // fixed bitstream patterns

    localparam int slice_hdr_len = 75;
    localparam logic [slice_hdr_len-1:0] slice_hdr =
        {32'd1, 43'b0110010110001000100000000010000000000001111};

    localparam int mb_hdr_len = 22;
    localparam logic [mb_hdr_len-1:0] mb_hdr = 22'b1111111111111111110111;

    localparam int trail_len = 32;
    localparam logic [trail_len-1:0] trail_word = {1'b1, 31'd0};  // stop bit and zero pad.

    //////////////////////////////////////////////////////////////////////
    // packer storage

    localparam int word_w    = 32;
    localparam int acc_w     = 256;
    localparam int acc_len_w = $clog2(acc_w) + 1;  // holds 0 to acc_w.
    localparam int buf_words = 64;
    localparam int addr_w    = $clog2(buf_words);
    localparam int count_w   = addr_w + 1;       // holds 0 to buf_words.

    // the first block of a slice adds the most bits.
    localparam int max_append = slice_hdr_len + mb_hdr_len + max_block_bits;

endpackage : h264_pkg

// File: rtl/block_scan.sv
module block_scan
    import h264_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic advance,
    output logic first_in_slice,
    output logic first_in_mb,
    output logic last_in_slice
);

    logic [pos_w-1:0] pos_x;
    logic [pos_w-1:0] pos_y;

    assign first_in_slice = (pos_x == '0) && (pos_y == '0);
    assign first_in_mb    = (pos_x[3:0] == 4'd0) && (pos_y[3:0] == 4'd0);
    assign last_in_slice  = (pos_x == pos_w'(last_x)) && (pos_y == pos_w'(last_y));

    // raster of 4x4 blocks inside a macroblock, raster of macroblocks in the frame.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            pos_x <= '0;
            pos_y <= '0;
        end else if (advance) begin
            if (last_in_slice) begin
                pos_x <= '0;
                pos_y <= '0;
            end else if (pos_x[3:0] != 4'd12) begin
                pos_x <= pos_x + pos_w'(4);    // next block in the row.
            end else if (pos_y[3:0] != 4'd12) begin
                pos_x <= pos_x - pos_w'(12);   // next block row, same mb.
                pos_y <= pos_y + pos_w'(4);
            end else if (pos_x + pos_w'(4) != pos_w'(frame_w)) begin
                pos_x <= pos_x + pos_w'(4);    // mb to the right.
                pos_y <= pos_y - pos_w'(12);
            end else begin
                pos_x <= '0;                   // first mb of the next mb row.
                pos_y <= pos_y + pos_w'(4);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    a_pos_in_frame : assert property (@(posedge clk) disable iff (rst)
        (pos_x < pos_w'(frame_w)) && (pos_y < pos_w'(frame_h))
        && (pos_x[1:0] == 2'd0) && (pos_y[1:0] == 2'd0));

endmodule : block_scan

// File: rtl/expgolomb_coder.sv
module expgolomb_coder
    import h264_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    input  logic [num_coefs*coef_w-1:0] in_coeffs,
    output logic                        in_ready,
    input  logic                        packer_ready,
    output logic                        code_valid,
    output logic [code_w-1:0]           code_bits,
    output logic [code_len_w-1:0]       code_len
);

    logic [code_w-1:0]     code_next;
    logic [code_len_w-1:0] len_next;

    //////////////////////////////////////////////////////////////////////
    // code mapping

    // code number plus one, which is the value the Exp-Golomb code carries.
    // v > 0 maps to 2v-1, otherwise to -2v.
    function automatic logic [3:0] code_value(input logic signed [coef_w-1:0] v);
        if (v > 0)
            return 4'(2 * v);
        else
            return 4'(1 - 2 * v);
    endfunction

    // leading zeros plus the binary value, so 2*nbits-1.
    function automatic logic [2:0] code_length(input logic [3:0] value);
        if (value[3])
            return 3'd7;
        else if (value[2])
            return 3'd5;
        else if (value[1])
            return 3'd3;
        else
            return 3'd1;
    endfunction

    // coefficient 0 sits in the top bits and ends up oldest in the code.
    always_comb begin
        code_next = '0;
        len_next  = '0;
        for (int i = 0; i < num_coefs; i++) begin
            logic [3:0] value;
            logic [2:0] len;
            value     = code_value(in_coeffs[(num_coefs-1-i)*coef_w +: coef_w]);
            len       = code_length(value);
            code_next = (code_next << len) | code_w'(value);
            len_next  = len_next + code_len_w'(len);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output stage

    assign in_ready = !code_valid || packer_ready;  // empty, or draining this cycle.

    always_ff @(posedge clk) begin
        if (rst) begin
            code_valid <= 1'b0;
        end else if (in_ready) begin
            code_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            code_bits <= code_next;
            code_len  <= len_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    a_len_max : assert property (@(posedge clk) disable iff (rst)
        code_valid |-> code_len <= code_len_w'(max_block_bits));

endmodule : expgolomb_coder

// File: rtl/bit_packer.sv
module bit_packer
    import h264_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  code_valid,
    input  logic [code_w-1:0]     code_bits,
    input  logic [code_len_w-1:0] code_len,
    input  logic                  first_in_slice,
    input  logic                  first_in_mb,
    input  logic                  last_in_slice,
    output logic                  ready,
    output logic                  blk_accept,
    input  logic [addr_w-1:0]     rd_addr,
    output logic [word_w-1:0]     rd_data,
    output logic [count_w-1:0]    word_count
);

    logic [acc_w-1:0]     acc;          // newest bits at the bottom.
    logic [acc_len_w-1:0] acc_len;
    logic [acc_w-1:0]     acc_next;
    logic [acc_len_w-1:0] acc_len_next;
    logic [acc_len_w-1:0] left_len;
    logic [word_w-1:0]    word_out;
    logic                 word_out_valid;
    logic                 buf_full;
    logic                 accept;

    logic [word_w-1:0]    mem [buf_words];

    //////////////////////////////////////////////////////////////////////
    // word extraction

    assign buf_full       = (word_count == count_w'(buf_words));
    assign word_out_valid = (acc_len >= acc_len_w'(word_w)) && !buf_full && !clear;
    assign left_len       = word_out_valid ? acc_len - acc_len_w'(word_w) : acc_len;
    assign word_out       = acc[acc_len - 1'b1 -: word_w];  // oldest 32 bits.

    // room for a worst case block after this cycle's word leaves.
    assign ready      = !clear && !buf_full && (left_len <= acc_len_w'(acc_w - max_append));
    assign accept     = code_valid && ready;
    assign blk_accept = accept;

    //////////////////////////////////////////////////////////////////////
    // append headers, code and trailer

    always_comb begin
        acc_next     = acc;
        acc_len_next = left_len;
        if (accept) begin
            if (first_in_slice) begin
                acc_next     = (acc_next << slice_hdr_len) | acc_w'(slice_hdr);
                acc_len_next = acc_len_next + acc_len_w'(slice_hdr_len);
            end
            if (first_in_mb) begin
                acc_next     = (acc_next << mb_hdr_len) | acc_w'(mb_hdr);
                acc_len_next = acc_len_next + acc_len_w'(mb_hdr_len);
            end
            acc_next     = (acc_next << code_len) | acc_w'(code_bits);
            acc_len_next = acc_len_next + acc_len_w'(code_len);
            if (last_in_slice) begin
                acc_next     = (acc_next << trail_len) | acc_w'(trail_word);
                acc_len_next = acc_len_next + acc_len_w'(trail_len);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc_len    <= '0;
            word_count <= '0;
        end else begin
            acc_len <= acc_len_next;
            if (word_out_valid) begin
                word_count <= word_count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output buffer

    always_ff @(posedge clk) begin
        if (clear) begin
            acc <= '0;
            for (int i = 0; i < buf_words; i++) begin
                mem[i] <= '0;
            end
        end else begin
            acc <= acc_next;
            if (word_out_valid) begin
                mem[word_count[addr_w-1:0]] <= word_out;
            end
        end
    end

    assign rd_data = mem[rd_addr];  // host read, no latency.

    //////////////////////////////////////////////////////////////////////
    // checks

    a_acc_len : assert property (@(posedge clk) disable iff (rst)
        acc_len <= acc_len_w'(acc_w));

    a_count : assert property (@(posedge clk) disable iff (rst)
        word_count <= count_w'(buf_words));

endmodule : bit_packer

// File: rtl/h264_slice_encoder.sv
module h264_slice_encoder
    import h264_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        block_valid,
    input  logic [num_coefs*coef_w-1:0] block_coeffs,
    output logic                        block_ready,
    input  logic                        buf_clear,
    input  logic [addr_w-1:0]           rd_addr,
    output logic [word_w-1:0]           rd_data,
    output logic [count_w-1:0]          word_count
);

    logic                  code_valid;
    logic [code_w-1:0]     code_bits;
    logic [code_len_w-1:0] code_len;
    logic                  packer_ready;
    logic                  blk_accept;
    logic                  first_in_slice;
    logic                  first_in_mb;
    logic                  last_in_slice;

    expgolomb_coder u_coder (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (block_valid),
        .in_coeffs    (block_coeffs),
        .in_ready     (block_ready),
        .packer_ready (packer_ready),
        .code_valid   (code_valid),
        .code_bits    (code_bits),
        .code_len     (code_len)
    );

    // position of the block whose code the coder presents.
    block_scan u_scan (
        .clk            (clk),
        .rst            (rst),
        .clear          (buf_clear),
        .advance        (blk_accept),
        .first_in_slice (first_in_slice),
        .first_in_mb    (first_in_mb),
        .last_in_slice  (last_in_slice)
    );

    bit_packer u_packer (
        .clk            (clk),
        .rst            (rst),
        .clear          (buf_clear),
        .code_valid     (code_valid),
        .code_bits      (code_bits),
        .code_len       (code_len),
        .first_in_slice (first_in_slice),
        .first_in_mb    (first_in_mb),
        .last_in_slice  (last_in_slice),
        .ready          (packer_ready),
        .blk_accept     (blk_accept),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .word_count     (word_count)
    );

endmodule : h264_slice_encoder

// File: sim/tb_h264_slice_encoder.sv
module tb_h264_slice_encoder
    import h264_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_tests      = 5;
    localparam int test_budget    = 600;  // cycles for the longest test, with margin.
    localparam int cycle_limit    = num_tests * test_budget;
    localparam int frame_blocks   = (frame_w / 4) * (frame_h / 4);
    localparam int partial_blocks = 17;   // one block into the second mb.

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        block_valid;
    logic [num_coefs*coef_w-1:0] block_coeffs;
    logic                        block_ready;
    logic                        buf_clear;
    logic [addr_w-1:0]           rd_addr;
    logic [word_w-1:0]           rd_data;
    logic [count_w-1:0]          word_count;

    int                          errors;
    int                          cycle_count = 0;
    logic [31:0]                 lcg_state;
    logic [num_coefs*coef_w-1:0] frame_coeffs [frame_blocks];
    logic                        exp_bits [$];  // reference stream, oldest bit first.

    always #4 clk = ~clk;

    h264_slice_encoder UUT (
        .clk          (clk),
        .rst          (rst),
        .block_valid  (block_valid),
        .block_coeffs (block_coeffs),
        .block_ready  (block_ready),
        .buf_clear    (buf_clear),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .word_count   (word_count)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus and reference model

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // mostly zero, like a quantized residual, so a frame fits the buffer.
    function automatic logic [coef_w-1:0] sparse_coeff();
        logic [31:0] r;
        r = lcg_next();
        if (r[23:21] != 3'd0) begin
            return '0;
        end
        case (r[17:16])
            2'd0:    return 3'b110;  // -2.
            2'd1:    return 3'b111;  // -1.
            2'd2:    return 3'b001;
            default: return 3'b010;
        endcase
    endfunction

    function automatic logic gap_now();
        logic [31:0] r;
        r = lcg_next();
        return r[29:28] == 2'd0;
    endfunction

    function automatic int code_number(input logic signed [coef_w-1:0] v);
        int iv;
        iv = v;
        if (iv > 0) begin
            return 2 * iv - 1;
        end
        return -2 * iv;
    endfunction

    task automatic push_bits(input logic [127:0] pattern, input int len);
        for (int k = len - 1; k >= 0; k--) begin
            exp_bits.push_back(pattern[k]);
        end
    endtask

    task automatic push_ue(input int cn);
        int value;
        int nbits;
        value = cn + 1;
        nbits = 0;
        for (int t = value; t > 0; t = t >> 1) begin
            nbits++;
        end
        push_bits(128'(0), nbits - 1);   // leading zeros.
        push_bits(128'(value), nbits);
    endtask

    task automatic model_stream(input int n_blocks);
        logic [num_coefs*coef_w-1:0] c;
        exp_bits.delete();
        for (int b = 0; b < n_blocks; b++) begin
            c = frame_coeffs[b];
            if (b == 0) begin
                push_bits(128'(slice_hdr), slice_hdr_len);
            end
            if (b % 16 == 0) begin
                push_bits(128'(mb_hdr), mb_hdr_len);
            end
            for (int i = 0; i < num_coefs; i++) begin
                push_ue(code_number(c[(num_coefs-1-i)*coef_w +: coef_w]));
            end
            if (b == frame_blocks - 1) begin
                push_bits(128'(trail_word), trail_len);
            end
        end
    endtask

    function automatic logic [count_w-1:0] expected_count();
        int n;
        n = exp_bits.size() / word_w;
        if (n > buf_words) begin
            n = buf_words;
        end
        return count_w'(n);
    endfunction

    function automatic logic [word_w-1:0] expected_word(input int idx);
        logic [word_w-1:0] w;
        for (int b = 0; b < word_w; b++) begin
            w[word_w-1-b] = exp_bits[idx*word_w + b];
        end
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare, drive and read

    task automatic check_word(input string test, input int idx,
                              input logic [word_w-1:0] expected, input logic [word_w-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s word %0d: expected %h, actual %h", test, idx, expected, actual);
        end
    endtask

    task automatic check_count(input string test, input logic [count_w-1:0] expected,
                               input logic [count_w-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s word_count: expected %0d, actual %0d", test, expected, actual);
        end
    endtask

    task automatic pulse_clear();
        buf_clear <= 1'b1;
        @(posedge clk);
        buf_clear <= 1'b0;
        @(posedge clk);
    endtask

    task automatic send_block(input logic [num_coefs*coef_w-1:0] coeffs);
        block_valid  <= 1'b1;
        block_coeffs <= coeffs;
        @(negedge clk);
        while (!block_ready) begin
            @(negedge clk);
        end
        @(posedge clk);   // transfer.
    endtask

    task automatic send_blocks(input int n_blocks, input bit gaps);
        for (int b = 0; b < n_blocks; b++) begin
            while (gaps && gap_now()) begin
                block_valid <= 1'b0;
                @(posedge clk);
            end
            send_block(frame_coeffs[b]);
        end
        block_valid <= 1'b0;
    endtask

    task automatic wait_words(input logic [count_w-1:0] target);
        @(negedge clk);
        while (word_count < target) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // a stray extra word would show by now.
        @(posedge clk);
    endtask

    task automatic check_words(input string test, input int n_words, input bit zero);
        for (int i = 0; i < n_words; i++) begin
            rd_addr <= addr_w'(i);
            @(negedge clk);
            check_word(test, i, zero ? '0 : expected_word(i), rd_data);
            @(posedge clk);
        end
    endtask

    task automatic check_frame(input string test);
        @(negedge clk);
        check_count(test, expected_count(), word_count);
        @(posedge clk);
        check_words(test, int'(expected_count()), 1'b0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests

    task automatic reset_state();
        @(negedge clk);
        check_count("reset_state", '0, word_count);
        if (block_ready !== 1'b1) begin
            errors++;
            $display("reset_state: block_ready is not high after reset");
        end
        @(posedge clk);
    endtask

    task automatic zero_frame();
        for (int b = 0; b < frame_blocks; b++) begin
            frame_coeffs[b] = '0;
        end
        model_stream(frame_blocks);
        send_blocks(frame_blocks, 1'b0);
        wait_words(expected_count());
        check_frame("zero_frame");
    endtask

    task automatic random_frame();
        for (int b = 0; b < frame_blocks; b++) begin
            for (int i = 0; i < num_coefs; i++) begin
                frame_coeffs[b][i*coef_w +: coef_w] = sparse_coeff();
            end
        end
        model_stream(frame_blocks);
        pulse_clear();
        send_blocks(frame_blocks, 1'b1);
        wait_words(expected_count());
        check_frame("random_frame");
    endtask

    task automatic clear_restart();
        for (int b = 0; b < frame_blocks; b++) begin
            frame_coeffs[b] = '0;
        end
        pulse_clear();
        model_stream(partial_blocks);
        send_blocks(partial_blocks, 1'b0);
        wait_words(expected_count());
        pulse_clear();
        @(negedge clk);
        check_count("clear_restart", '0, word_count);
        @(posedge clk);
        check_words("clear_restart", 4, 1'b1);
        model_stream(frame_blocks);   // slice header leads again.
        send_blocks(frame_blocks, 1'b0);
        wait_words(expected_count());
        check_frame("clear_restart");
    endtask

    task automatic buffer_full();
        for (int b = 0; b < frame_blocks; b++) begin
            frame_coeffs[b] = {num_coefs{3'b100}};   // all -4, longest codes.
        end
        pulse_clear();
        model_stream(frame_blocks);
        block_valid  <= 1'b1;
        block_coeffs <= frame_coeffs[0];
        wait_words(expected_count());
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (block_ready !== 1'b0) begin
                errors++;
                $display("buffer_full: block_ready is high while the buffer is full");
            end
        end
        @(posedge clk);
        block_valid <= 1'b0;
        check_frame("buffer_full");
    endtask

    initial begin
        lcg_state    = 32'h72a6_6ab4;
        errors       = 0;
        rst          = 1'b1;
        block_valid  = 1'b0;
        block_coeffs = '0;
        buf_clear    = 1'b0;
        rd_addr      = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_state();
        zero_frame();
        random_frame();
        clear_restart();
        buffer_full();
        $display("tests complete, %0d error(s)", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_h264_slice_encoder

// File: sim.f
rtl/h264_pkg.sv
rtl/block_scan.sv
rtl/expgolomb_coder.sv
rtl/bit_packer.sv
rtl/h264_slice_encoder.sv
sim/tb_h264_slice_encoder.sv
